//--- source/floo_noc_pkg.sv
/*
 * Mesh topology definitions for the router
 * Port directions, node coordinates and one-hot route masks
 */

package floo_noc_pkg;

  // Four mesh neighbours plus the local endpoint
  localparam int unsigned NumPorts = 5;

  // Enough for a 4x4 mesh
  localparam int unsigned CoordWidth = 2;

  // Order matters, it is the port index everywhere
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } port_e;

  typedef logic [CoordWidth-1:0] coord_t;

  // Position of a node in the mesh
  typedef struct packed {
    coord_t x;
    coord_t y;
  } node_id_t;

  // One bit per output port, indexed by port_e
  typedef logic [NumPorts-1:0] route_mask_t;

endpackage

//--- source/floo_flit_pkg.sv
/*
 * Flit format carried on every router link
 * Destination header, tail marker and payload
 */

package floo_flit_pkg;

  import floo_noc_pkg::*;

  localparam int unsigned PayloadWidth = 16;

  typedef logic [PayloadWidth-1:0] payload_t;

  // All flits of a packet repeat the destination,
  // so every flit can be routed on its own
  typedef struct packed {
    node_id_t dst;
    logic     last;
    payload_t payload;
  } flit_t;

endpackage

//--- source/floo_fifo.sv
/*
 * Flit FIFO with valid/ready on both sides
 * Circular buffer with registered fill count, one cycle write-to-read latency
 */

`timescale 1ns/10ps

module floo_fifo
  import floo_flit_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  flit_t mem_q [FifoDepth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  count_q;
  logic  full;
  logic  push;
  logic  pop;

  function automatic ptr_t ptr_next(ptr_t ptr);
    return (ptr == ptr_t'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // A full FIFO stays full for the cycle in which it is read
  assign full    = (count_q == cnt_t'(FifoDepth));
  assign ready_o = !full;
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

  // Fill level never grows past a full cycle
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    full |=> (count_q <= $past(count_q)))
    else $error("flit FIFO written while full");

endmodule

//--- source/floo_input_port.sv
/*
 * Router input port
 * Buffers incoming flits and computes the XY output for the head flit
 */

`timescale 1ns/10ps

module floo_input_port
  import floo_noc_pkg::*;
  import floo_flit_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  node_id_t    node_id_i,
  input  logic        valid_i,
  output logic        ready_o,
  input  flit_t       data_i,
  output logic        valid_o,
  input  logic        ready_i,
  output flit_t       data_o,
  output route_mask_t route_o
);

  node_id_t head_dst;

  floo_fifo #(
    .FifoDepth ( FifoDepth )
  ) u_fifo (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .valid_i  ( valid_i  ),
    .ready_o  ( ready_o  ),
    .data_i   ( data_i   ),
    .valid_o  ( valid_o  ),
    .ready_i  ( ready_i  ),
    .data_o   ( data_o   )
  );

  assign head_dst = data_o.dst;

  // Dimension-ordered routing, X first then Y
  always_comb begin
    route_o = '0;
    if (head_dst.x > node_id_i.x) begin
      route_o[East] = 1'b1;
    end else if (head_dst.x < node_id_i.x) begin
      route_o[West] = 1'b1;
    end else if (head_dst.y > node_id_i.y) begin
      route_o[North] = 1'b1;
    end else if (head_dst.y < node_id_i.y) begin
      route_o[South] = 1'b1;
    end else begin
      // Destination reached
      route_o[Eject] = 1'b1;
    end
  end

endmodule

//--- source/floo_wormhole_arbiter.sv
/*
 * Wormhole arbiter for one router output
 * Round-robin over the inputs, grant held until the tail flit has passed
 */

`timescale 1ns/10ps

module floo_wormhole_arbiter
  import floo_noc_pkg::*;
  import floo_flit_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic  [NumPorts-1:0] valid_i,
  output logic  [NumPorts-1:0] ready_o,
  input  flit_t [NumPorts-1:0] data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output flit_t                data_o
);

  typedef enum logic {
    Idle,
    Locked
  } arb_state_e;

  typedef logic [$clog2(NumPorts)-1:0] port_idx_t;

  arb_state_e state_q, state_d;
  port_idx_t  rr_q, rr_d;
  port_idx_t  lock_q, lock_d;
  port_idx_t  sel;
  logic       req_sel;

  function automatic port_idx_t idx_next(port_idx_t idx);
    return (idx == port_idx_t'(NumPorts - 1)) ? '0 : idx + 1'b1;
  endfunction

  // Pick the first requester at or after the pointer,
  // or stay on the locked input mid-packet
  always_comb begin : p_select
    int cand;
    sel     = rr_q;
    req_sel = 1'b0;
    for (int i = NumPorts - 1; i >= 0; i--) begin
      cand = (int'(rr_q) + i) % NumPorts;
      if (valid_i[cand]) begin
        sel     = port_idx_t'(cand);
        req_sel = 1'b1;
      end
    end
    if (state_q == Locked) begin
      sel     = lock_q;
      req_sel = valid_i[lock_q];
    end
  end

  assign valid_o = req_sel;
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = req_sel && ready_i;
  end

  // Lock as soon as a flit is offered, so a stalled output keeps its flit
  always_comb begin
    state_d = state_q;
    lock_d  = lock_q;
    rr_d    = rr_q;
    if (valid_o) begin
      if (ready_i && data_o.last) begin
        state_d = Idle;
        rr_d    = idx_next(sel);
      end else begin
        state_d = Locked;
        lock_d  = sel;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= Idle;
      rr_q    <= port_idx_t'(North);
      lock_q  <= port_idx_t'(North);
    end else begin
      state_q <= state_d;
      rr_q    <= rr_d;
      lock_q  <= lock_d;
    end
  end

endmodule

//--- source/floo_switch.sv
/*
 * Router crossbar
 * Masks input requests per output, one wormhole arbiter per output
 */

`timescale 1ns/10ps

module floo_switch
  import floo_noc_pkg::*;
  import floo_flit_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic        [NumPorts-1:0] in_valid_i,
  input  route_mask_t [NumPorts-1:0] in_route_i,
  input  flit_t       [NumPorts-1:0] in_data_i,
  output logic        [NumPorts-1:0] in_ready_o,
  output logic        [NumPorts-1:0] valid_o,
  input  logic        [NumPorts-1:0] ready_i,
  output flit_t       [NumPorts-1:0] data_o
);

  // Requests and grants indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] req;
  logic [NumPorts-1:0][NumPorts-1:0] gnt;
  // Grants regrouped as [input][output]
  logic [NumPorts-1:0][NumPorts-1:0] gnt_in;

  for (genvar op = 0; op < NumPorts; op++) begin : gen_output
    for (genvar ip = 0; ip < NumPorts; ip++) begin : gen_input
      // No path back out of the port a flit came in on
      if (ip == op) begin : gen_no_loop
        assign req[op][ip] = 1'b0;
      end else begin : gen_conn
        assign req[op][ip] = in_valid_i[ip] && in_route_i[ip][op];
      end
      assign gnt_in[ip][op] = gnt[op][ip];
    end

    floo_wormhole_arbiter u_arbiter (
      .clk_i    ( clk_i       ),
      .arst_n_i ( arst_n_i    ),
      .valid_i  ( req[op]     ),
      .ready_o  ( gnt[op]     ),
      .data_i   ( in_data_i   ),
      .valid_o  ( valid_o[op] ),
      .ready_i  ( ready_i[op] ),
      .data_o   ( data_o[op]  )
    );
  end

  for (genvar ip = 0; ip < NumPorts; ip++) begin : gen_ready
    // An input requests a single output, so at most one grant comes back
    assign in_ready_o[ip] = |gnt_in[ip];

    a_no_loopback: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(in_valid_i[ip] && in_route_i[ip][ip]))
      else $error("input %0d routed back to itself", ip);

    if (ip == int'(North) || ip == int'(South)) begin : gen_y_input
      a_no_y_to_x: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(in_valid_i[ip] && (in_route_i[ip][East] || in_route_i[ip][West])))
        else $error("Y-to-X turn requested by input %0d", ip);
    end
  end

endmodule

//--- source/floo_router.sv
/*
 * Five-port XY mesh router
 * Input FIFOs with route computation, wormhole switch, valid/ready links
 */

`timescale 1ns/10ps

module floo_router
  import floo_noc_pkg::*;
  import floo_flit_pkg::*;
#(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  node_id_t             node_id_i,
  input  logic  [NumPorts-1:0] valid_i,
  output logic  [NumPorts-1:0] ready_o,
  input  flit_t [NumPorts-1:0] data_i,
  output logic  [NumPorts-1:0] valid_o,
  input  logic  [NumPorts-1:0] ready_i,
  output flit_t [NumPorts-1:0] data_o
);

  logic        [NumPorts-1:0] in_valid;
  logic        [NumPorts-1:0] in_ready;
  flit_t       [NumPorts-1:0] in_data;
  route_mask_t [NumPorts-1:0] in_route;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_input
    floo_input_port #(
      .FifoDepth ( FifoDepth )
    ) u_input_port (
      .clk_i     ( clk_i       ),
      .arst_n_i  ( arst_n_i    ),
      .node_id_i ( node_id_i   ),
      .valid_i   ( valid_i[p]  ),
      .ready_o   ( ready_o[p]  ),
      .data_i    ( data_i[p]   ),
      .valid_o   ( in_valid[p] ),
      .ready_i   ( in_ready[p] ),
      .data_o    ( in_data[p]  ),
      .route_o   ( in_route[p] )
    );
  end

  floo_switch u_switch (
    .clk_i      ( clk_i    ),
    .arst_n_i   ( arst_n_i ),
    .in_valid_i ( in_valid ),
    .in_route_i ( in_route ),
    .in_data_i  ( in_data  ),
    .in_ready_o ( in_ready ),
    .valid_o    ( valid_o  ),
    .ready_i    ( ready_i  ),
    .data_o     ( data_o   )
  );

  // Link rules on both sides of every port
  for (genvar p = 0; p < NumPorts; p++) begin : gen_link_check
    a_in_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_i[p] && !ready_o[p] |=> valid_i[p] && $stable(data_i[p]))
      else $error("input link %0d dropped or changed a pending flit", p);

    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_o[p] && !ready_i[p] |=> valid_o[p] && $stable(data_o[p]))
      else $error("output link %0d dropped or changed a pending flit", p);
  end

endmodule

//--- verification/tb_floo_router.sv
/*
 * Testbench for the five-port XY mesh router
 * LFSR-driven legal traffic, reference XY routing, per-source scoreboards
 */

`timescale 1ns/10ps

module tb_floo_router
  import floo_noc_pkg::*;
  import floo_flit_pkg::*;
();

  localparam node_id_t OwnId = '{x: 2'd1, y: 2'd1};

  logic                 clk = 1'b0;
  logic                 arst_n = 1'b0;
  logic  [NumPorts-1:0] valid_i = '0;
  logic  [NumPorts-1:0] ready_o;
  flit_t [NumPorts-1:0] data_i = '0;
  logic  [NumPorts-1:0] valid_o;
  logic  [NumPorts-1:0] ready_i = '0;
  flit_t [NumPorts-1:0] data_o;

  logic [31:0]          lfsr_state = 32'h8e4e;
  logic [NumPorts-1:0]  ready_hold = '1;
  logic [NumPorts-1:0]  acc = '0;
  bit                   rand_mode = 1'b0;
  string                cur_test = "reset";
  int                   errors = 0;
  int                   checks = 0;
  int unsigned          seq [NumPorts];
  int                   acc_count [NumPorts];
  int                   out_count [NumPorts];
  int                   eject_srcs [$];
  // Pending flits per input, and expected flits per [output][source]
  flit_t                tx_q [NumPorts][$];
  flit_t                sb_q [NumPorts][NumPorts][$];
  logic                 in_pkt [NumPorts];
  int                   pkt_src [NumPorts];

  floo_router #(
    .FifoDepth ( 4 )
  ) u_dut (
    .clk_i     ( clk     ),
    .arst_n_i  ( arst_n  ),
    .node_id_i ( OwnId   ),
    .valid_i   ( valid_i ),
    .ready_o   ( ready_o ),
    .data_i    ( data_i  ),
    .valid_o   ( valid_o ),
    .ready_i   ( ready_i ),
    .data_o    ( data_o  )
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int unsigned rand_bits(int unsigned n);
    int unsigned r;
    logic        fb;
    r = 0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = (r << 1) | int'(fb);
    end
    return r;
  endfunction

  // Reference XY routing, X dimension first
  function automatic int xy_route(node_id_t dst, node_id_t own);
    if (dst.x > own.x) return int'(East);
    if (dst.x < own.x) return int'(West);
    if (dst.y > own.y) return int'(North);
    if (dst.y < own.y) return int'(South);
    return int'(Eject);
  endfunction

  // Legal destination for a source: no U-turn, no Y-to-X turn
  function automatic node_id_t pick_dst(int src);
    node_id_t dst;
    bit       ok;
    ok  = 1'b0;
    dst = OwnId;
    while (!ok) begin
      dst = node_id_t'(4'(rand_bits(4)));
      ok  = (xy_route(dst, OwnId) != src);
      if ((src == int'(North) || src == int'(South)) && dst.x != OwnId.x) ok = 1'b0;
      if (src == int'(Eject) && dst == OwnId) ok = 1'b0;
    end
    return dst;
  endfunction

  function automatic bit all_idle();
    bit idle;
    idle = (valid_i == '0);
    for (int p = 0; p < NumPorts; p++) begin
      if (tx_q[p].size() != 0) idle = 1'b0;
      for (int q = 0; q < NumPorts; q++) begin
        if (sb_q[p][q].size() != 0) idle = 1'b0;
      end
    end
    return idle;
  endfunction

  task automatic value_error(string what, logic [31:0] exp_v, logic [31:0] act_v);
    errors++;
    $display("FAILED %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp_v, act_v);
  endtask

  task automatic plain_error(string msg);
    errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  // Payload holds the source port on top and a sequence number below
  task automatic send_packet(int src, node_id_t dst, int len);
    flit_t f;
    for (int i = 0; i < len; i++) begin
      f.dst     = dst;
      f.last    = (i == len - 1);
      f.payload = {3'(src), 13'(seq[src])};
      seq[src]++;
      tx_q[src].push_back(f);
    end
  endtask

  // Main sequence acts just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle(int limit);
    int cycles;
    cycles = 0;
    while (!all_idle() && cycles < limit) begin
      tick();
      cycles++;
    end
    if (!all_idle()) begin
      plain_error($sformatf("traffic did not drain within %0d cycles", limit));
    end
  endtask

  // Driver on the falling edge, valid held until the flit is taken
  always @(negedge clk) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (acc[p]) begin
        tx_q[p].delete(0);
        valid_i[p] = 1'b0;
      end
      if (!valid_i[p] && tx_q[p].size() != 0) begin
        if (!rand_mode || rand_bits(1) == 1) begin
          valid_i[p] = 1'b1;
          data_i[p]  = tx_q[p][0];
        end
      end
      ready_i[p] = rand_mode ? (rand_bits(2) != 0) : ready_hold[p];
    end
  end

  // Scoreboard process, compares every output transfer
  always @(posedge clk) begin : p_monitor
    flit_t f;
    int    src;
    int    exp_op;
    if (arst_n) begin
      for (int op = 0; op < NumPorts; op++) begin
        if (valid_o[op] && ready_i[op]) begin
          f      = data_o[op];
          src    = int'(f.payload[15:13]);
          exp_op = xy_route(f.dst, OwnId);
          checks++;
          if (exp_op != op) value_error("output port", exp_op, op);
          if (src >= NumPorts) begin
            plain_error($sformatf("flit on output %0d has no valid source", op));
          end else if (sb_q[op][src].size() == 0) begin
            plain_error($sformatf("output %0d sent a flit that input %0d never sent", op, src));
          end else begin
            checks++;
            if (sb_q[op][src][0] != f) value_error("flit", sb_q[op][src][0], f);
            sb_q[op][src].delete(0);
          end
          // Wormhole contiguity within a packet
          checks++;
          if (in_pkt[op] && src != pkt_src[op]) value_error("packet source", pkt_src[op], src);
          in_pkt[op]  = !f.last;
          pkt_src[op] = src;
          if (f.last && op == int'(Eject)) eject_srcs.push_back(src);
          out_count[op]++;
        end
      end
      for (int ip = 0; ip < NumPorts; ip++) begin
        acc[ip] = valid_i[ip] && ready_o[ip];
        if (acc[ip]) begin
          sb_q[xy_route(data_i[ip].dst, OwnId)][ip].push_back(data_i[ip]);
          acc_count[ip]++;
        end
      end
    end
  end

  initial begin : p_main
    int cycles;
    int acc_base;
    int out_base;
    int total_in;
    int total_out;
    for (int p = 0; p < NumPorts; p++) begin
      seq[p]       = 0;
      acc_count[p] = 0;
      out_count[p] = 0;
      in_pkt[p]    = 1'b0;
      pkt_src[p]   = 0;
    end
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    tick();
    checks += 2;
    if (valid_o != '0) value_error("valid_o after reset", 0, valid_o);
    if (ready_o != '1) value_error("ready_o after reset", 5'h1f, ready_o);

    cur_test = "routing";
    for (int p = 0; p < NumPorts; p++) begin
      for (int i = 0; i < 6; i++) send_packet(p, pick_dst(p), 1);
    end
    wait_idle(300);

    // Several sources converge on the North output
    cur_test = "wormhole";
    for (int i = 0; i < 5; i++) begin
      send_packet(East, node_id_t'{x: 2'd1, y: 2'd3}, int'(rand_bits(2)) + 1);
      send_packet(West, node_id_t'{x: 2'd1, y: 2'd2}, int'(rand_bits(2)) + 1);
      send_packet(South, node_id_t'{x: 2'd1, y: 2'd3}, int'(rand_bits(2)) + 1);
      send_packet(Eject, node_id_t'{x: 2'd1, y: 2'd2}, int'(rand_bits(2)) + 1);
    end
    wait_idle(500);

    cur_test = "round_robin";
    eject_srcs.delete();
    for (int i = 0; i < 8; i++) begin
      send_packet(North, OwnId, int'(rand_bits(1)) + 1);
      send_packet(West, OwnId, int'(rand_bits(1)) + 1);
    end
    wait_idle(300);
    checks++;
    if (eject_srcs.size() != 16) value_error("packets on Eject", 16, eject_srcs.size());
    for (int i = 1; i < eject_srcs.size(); i++) begin
      checks++;
      if (eject_srcs[i] == eject_srcs[i-1]) begin
        value_error("packet source on Eject",
                    (eject_srcs[i-1] == int'(North)) ? int'(West) : int'(North),
                    eject_srcs[i]);
      end
    end

    // East stalled, South to North keeps going
    cur_test = "backpressure";
    ready_hold       = '1;
    ready_hold[East] = 1'b0;
    acc_base = acc_count[West];
    out_base = out_count[North];
    for (int i = 0; i < 6; i++) send_packet(West, node_id_t'{x: 2'd3, y: 2'd0}, 1);
    for (int i = 0; i < 4; i++) send_packet(South, node_id_t'{x: 2'd1, y: 2'd3}, 1);
    cycles = 0;
    while (acc_count[West] - acc_base < 4 && cycles < 100) begin
      tick();
      cycles++;
    end
    if (acc_count[West] - acc_base < 4) plain_error("West input stopped short of 4 flits");
    for (int i = 0; i < 20; i++) tick();
    checks += 2;
    if (acc_count[West] - acc_base != 4) begin
      value_error("flits accepted while stalled", 4, acc_count[West] - acc_base);
    end
    if (ready_o[West] != 1'b0) value_error("West ready_o while stalled", 0, ready_o[West]);
    cycles = 0;
    while (out_count[North] - out_base < 4 && cycles < 100) begin
      tick();
      cycles++;
    end
    if (out_count[North] - out_base < 4) plain_error("South to North traffic stalled with East");
    ready_hold[East] = 1'b1;
    wait_idle(300);

    cur_test = "stress";
    rand_mode = 1'b1;
    for (int c = 0; c < 4000; c++) begin
      for (int p = 0; p < NumPorts; p++) begin
        if (tx_q[p].size() < 3) send_packet(p, pick_dst(p), int'(rand_bits(2)) + 1);
      end
      tick();
    end
    rand_mode = 1'b0;
    wait_idle(2000);
    total_in  = 0;
    total_out = 0;
    for (int p = 0; p < NumPorts; p++) begin
      total_in  += acc_count[p];
      total_out += out_count[p];
    end
    checks++;
    if (total_in != total_out) value_error("flits delivered", total_in, total_out);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
source/floo_noc_pkg.sv
source/floo_flit_pkg.sv
source/floo_fifo.sv
source/floo_input_port.sv
source/floo_wormhole_arbiter.sv
source/floo_switch.sv
source/floo_router.sv
verification/tb_floo_router.sv

//--- run.sh
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_floo_router -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
